/* lsu.f */
hdl/lsu_pkg.sv
hdl/stp_block.sv
hdl/lsu_rd_chan.sv
hdl/lsu_wr_chan.sv
hdl/lsu.sv
verif/lsu_sva.sv
verif/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - hdl/lsu_pkg.sv
  - hdl/stp_block.sv
  - hdl/lsu_rd_chan.sv
  - hdl/lsu_wr_chan.sv
  - hdl/lsu.sv
  - target: test
    files:
      - verif/lsu_sva.sv
      - verif/lsu_tb.sv

/* verif/lsu_tb.sv */
`timescale 1ns/10ps

module lsu_tb;

	typedef struct {
		string name;
		lsu_pkg::lsu_op_e op;
		lsu_pkg::xlen_t addr;
		lsu_pkg::xlen_t data;
		lsu_pkg::rd_tag_t rd;
		logic commit;
		logic flush;
		lsu_pkg::xlen_t exp;
		logic exp_fault;
		logic exp_wr;
	} vec_t;

	localparam int NVEC = 18;

	logic CLK, rst_i, issue_valid_i, commit_i, flush_i;
	lsu_pkg::lsu_op_e issue_op_i;
	lsu_pkg::xlen_t issue_addr_i, issue_wdata_i, axi_wdata_o, axi_rdata_i, wb_res_o;
	lsu_pkg::rd_tag_t issue_rd_i, wb_rd_o;
	logic issue_ready_o, wb_valid_o, fault_o, fencei_o;
	lsu_pkg::paddr_t axi_awaddr_o, axi_araddr_o;
	lsu_pkg::strb_t axi_wstrb_o;
	logic axi_awvalid_o, axi_awready_i, axi_wvalid_o, axi_wready_i, axi_bvalid_i, axi_bready_o;
	logic axi_arvalid_o, axi_arready_i, axi_rvalid_i, axi_rready_o;

	// bus memory model state
	lsu_pkg::xlen_t mem [256];
	int ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt, ar_count, wr_count;
	logic r_pend, aw_got, w_got, b_pend, wr_busy;
	lsu_pkg::paddr_t r_addr, aw_a;
	lsu_pkg::xlen_t w_d;
	lsu_pkg::strb_t w_s;

	vec_t tbl [NVEC];
	vec_t e;
	int wr0, ar0;
	logic is_ld;

	lsu lsu_inst (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// reads wait behind any write still on the bus
	assign wr_busy = aw_got | w_got | axi_awvalid_o | axi_wvalid_o;

	always @(posedge CLK) begin
		if (rst_i) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= {32'(i) ^ 32'h5a5a0000, ~32'(i)};
			end
			mem[8'h20] <= 64'hfedc_ba98_8765_4321;
			mem[8'h21] <= 64'h0011_2233_4455_6677;
			mem[8'h22] <= 64'h0123_4567_89ab_cdef;
			{axi_arready_i, axi_rvalid_i, axi_awready_i, axi_wready_i, axi_bvalid_i} <= '0;
			axi_rdata_i <= '0;
			{r_pend, aw_got, w_got, b_pend} <= '0;
			{ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt, ar_count, wr_count} <= '0;
		end else begin
			if (axi_arvalid_o & axi_arready_i) begin
				axi_arready_i <= 1'b0;
				r_pend <= 1'b1;
				r_addr <= axi_araddr_o;
				ar_cnt <= $urandom % 4;
				ar_count <= ar_count + 1;
			end else if (axi_arvalid_o) begin
				if (ar_cnt == 0) axi_arready_i <= 1'b1;
				else ar_cnt <= ar_cnt - 1;
			end
			if (axi_rvalid_i & axi_rready_o) begin
				axi_rvalid_i <= 1'b0;
				r_pend <= 1'b0;
				r_cnt <= $urandom % 4;
			end else if (r_pend & !axi_rvalid_i & !wr_busy) begin
				if (r_cnt == 0) begin
					axi_rvalid_i <= 1'b1;
					axi_rdata_i <= mem[r_addr[10:3]];
				end else r_cnt <= r_cnt - 1;
			end
			if (axi_awvalid_o & axi_awready_i) begin
				axi_awready_i <= 1'b0;
				aw_got <= 1'b1;
				aw_a <= axi_awaddr_o;
				aw_cnt <= $urandom % 4;
			end else if (axi_awvalid_o) begin
				if (aw_cnt == 0) axi_awready_i <= 1'b1;
				else aw_cnt <= aw_cnt - 1;
			end
			if (axi_wvalid_o & axi_wready_i) begin
				axi_wready_i <= 1'b0;
				w_got <= 1'b1;
				w_d <= axi_wdata_o;
				w_s <= axi_wstrb_o;
				w_cnt <= $urandom % 4;
			end else if (axi_wvalid_o) begin
				if (w_cnt == 0) axi_wready_i <= 1'b1;
				else w_cnt <= w_cnt - 1;
			end
			// byte-wise write once address and data are both in
			if (aw_got & w_got) begin
				for (int b = 0; b < 8; b++) begin
					if (w_s[b]) mem[aw_a[10:3]][8*b +: 8] <= w_d[8*b +: 8];
				end
				{aw_got, w_got} <= 2'b00;
				b_pend <= 1'b1;
				wr_count <= wr_count + 1;
			end
			if (axi_bvalid_i & axi_bready_o) begin
				axi_bvalid_i <= 1'b0;
				b_pend <= 1'b0;
				b_cnt <= $urandom % 4;
			end else if (b_pend & !axi_bvalid_i) begin
				if (b_cnt == 0) axi_bvalid_i <= 1'b1;
				else b_cnt <= b_cnt - 1;
			end
		end
	end

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout after 200 cycles while waiting for %s", what);
		stop_run();
	endtask

	task automatic check_res(input string name, input lsu_pkg::xlen_t exp,
		input lsu_pkg::xlen_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_tag(input string name, input lsu_pkg::rd_tag_t exp,
		input lsu_pkg::rd_tag_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!issue_ready_o) begin
			@(posedge CLK);
			n++;
			if (n > 200) timeout_fail("issue_ready_o");
		end
	endtask

	task automatic wait_wb();
		int n;
		n = 0;
		do begin
			@(posedge CLK);
			n++;
			if (n > 200) timeout_fail("wb_valid_o");
		end while (!wb_valid_o);
	endtask

	task automatic wait_write(input int target);
		int n;
		n = 0;
		while (wr_count != target) begin
			@(posedge CLK);
			n++;
			if (n > 200) timeout_fail("the bus write of a committed store");
		end
	endtask

	task automatic pulse_commit();
		commit_i <= 1'b1;
		@(posedge CLK);
		commit_i <= 1'b0;
	endtask

	task automatic pulse_flush();
		flush_i <= 1'b1;
		@(posedge CLK);
		flush_i <= 1'b0;
	endtask

	initial begin
		tbl[0] = '{"lb_sext", lsu_pkg::LB, 64'h103, 64'h0, 7'd1, 0, 0, 64'hffff_ffff_ffff_ff87, 0, 0};
		tbl[1] = '{"lbu", lsu_pkg::LBU, 64'h105, 64'h0, 7'd2, 0, 0, 64'h0000_0000_0000_00ba, 0, 0};
		tbl[2] = '{"lh_sext", lsu_pkg::LH, 64'h106, 64'h0, 7'd3, 0, 0, 64'hffff_ffff_ffff_fedc, 0, 0};
		tbl[3] = '{"lhu", lsu_pkg::LHU, 64'h102, 64'h0, 7'd4, 0, 0, 64'h0000_0000_0000_8765, 0, 0};
		tbl[4] = '{"lw_sext", lsu_pkg::LW, 64'h100, 64'h0, 7'd5, 0, 0, 64'hffff_ffff_8765_4321, 0, 0};
		tbl[5] = '{"lwu", lsu_pkg::LWU, 64'h104, 64'h0, 7'd6, 0, 0, 64'h0000_0000_fedc_ba98, 0, 0};
		tbl[6] = '{"ld", lsu_pkg::LD, 64'h100, 64'h0, 7'h45, 0, 0, 64'hfedc_ba98_8765_4321, 0, 0};
		tbl[7] = '{"sh_commit", lsu_pkg::SH, 64'h10a, 64'h1234_beef, 7'd8, 1, 0,
			64'h0011_2233_beef_6677, 0, 1};
		tbl[8] = '{"sb_flush", lsu_pkg::SB, 64'h111, 64'ha5, 7'd9, 0, 1,
			64'h0123_4567_89ab_cdef, 0, 0};
		tbl[9] = '{"ld_unchanged", lsu_pkg::LD, 64'h110, 64'h0, 7'd10, 0, 0,
			64'h0123_4567_89ab_cdef, 0, 0};
		tbl[10] = '{"sd_pending", lsu_pkg::SD, 64'h118, 64'hcafe_f00d_1234_5678, 7'd11, 0, 0,
			64'h0, 0, 0};
		tbl[11] = '{"ld_hazard", lsu_pkg::LD, 64'h118, 64'h0, 7'd12, 1, 0,
			64'hcafe_f00d_1234_5678, 0, 1};
		tbl[12] = '{"ld_flushed", lsu_pkg::LD, 64'h108, 64'h0, 7'd13, 0, 1, 64'h0, 0, 0};
		tbl[13] = '{"lwu_after", lsu_pkg::LWU, 64'h10c, 64'h0, 7'd14, 0, 0, 64'h0011_2233, 0, 0};
		tbl[14] = '{"flt_upper", lsu_pkg::LW, 64'h1_0000_0100, 64'h0, 7'd15, 0, 1, 64'h0, 1, 0};
		tbl[15] = '{"flt_misalign", lsu_pkg::LH, 64'h101, 64'h0, 7'd16, 0, 1, 64'h0, 1, 0};
		tbl[16] = '{"fence", lsu_pkg::FENCE, 64'h0, 64'h0, 7'd17, 0, 0, 64'h0, 0, 0};
		tbl[17] = '{"fence_i", lsu_pkg::FENCE_I, 64'h0, 64'h0, 7'd18, 0, 0, 64'h0, 0, 0};

		void'($urandom(18));
		rst_i = 1'b1;
		issue_valid_i = 1'b0;
		issue_op_i = lsu_pkg::NOP;
		issue_addr_i = '0;
		issue_wdata_i = '0;
		issue_rd_i = '0;
		commit_i = 1'b0;
		flush_i = 1'b0;
		repeat (5) @(posedge CLK);
		rst_i <= 1'b0;
		@(posedge CLK);

		for (int k = 0; k < NVEC; k++) begin
			e = tbl[k];
			wait_ready();
			wr0 = wr_count;
			ar0 = ar_count;
			issue_valid_i <= 1'b1;
			issue_op_i <= e.op;
			issue_addr_i <= e.addr;
			issue_wdata_i <= e.data;
			issue_rd_i <= e.rd;
			@(posedge CLK);
			issue_valid_i <= 1'b0;
			check_bit({e.name, " fencei"}, e.op == lsu_pkg::FENCE_I, fencei_o);
			is_ld = e.op inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LD,
				lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU};
			if (!is_ld || e.exp_fault) begin
				// fixed N+1 writeback of zero
				@(posedge CLK);
				check_bit({e.name, " wb_valid"}, 1'b1, wb_valid_o);
				check_res({e.name, " wb_res"}, '0, wb_res_o);
				check_tag({e.name, " wb_rd"}, e.rd, wb_rd_o);
				check_bit({e.name, " fault"}, e.exp_fault, fault_o);
				if (e.commit) begin
					pulse_commit();
					wait_write(wr0 + 1);
				end else if (e.flush) begin
					pulse_flush();
				end
				if (!e.commit) begin
					repeat (8) @(posedge CLK);
					check_bit({e.name, " no write"}, 1'b1, wr_count == wr0);
				end
				check_bit({e.name, " no read"}, 1'b1, ar_count == ar0);
				if (!is_ld && (e.commit || e.flush) && !e.exp_fault) begin
					check_res({e.name, " memory"}, e.exp, mem[e.addr[10:3]]);
				end
				if (e.exp_fault && e.flush) begin
					check_bit({e.name, " fault cleared"}, 1'b0, fault_o);
				end
			end else if (e.flush) begin
				pulse_flush();
				for (int n = 0; !issue_ready_o; n++) begin
					check_bit({e.name, " no writeback"}, 1'b0, wb_valid_o);
					if (n > 200) timeout_fail("issue_ready_o after a flushed load");
					@(posedge CLK);
				end
				check_bit({e.name, " no writeback"}, 1'b0, wb_valid_o);
			end else begin
				if (e.commit) begin
					// load held behind the buffered store
					repeat (5) begin
						@(posedge CLK);
						check_bit({e.name, " arvalid held"}, 1'b0, axi_arvalid_o);
						check_bit({e.name, " ready low"}, 1'b0, issue_ready_o);
					end
					pulse_commit();
				end
				wait_wb();
				check_res({e.name, " wb_res"}, e.exp, wb_res_o);
				check_tag({e.name, " wb_rd"}, e.rd, wb_rd_o);
				check_bit({e.name, " ready at wb"}, 1'b1, issue_ready_o);
				check_bit({e.name, " write drained"}, e.exp_wr, wr_count == wr0 + 1);
			end
		end

		if (lsu_inst.sva_inst.fail_cnt != 0) begin
			stop_run();
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

/* verif/lsu_sva.sv */
`timescale 1ns/10ps

module lsu_sva (
	input logic CLK,
	input logic rst_i,
	input logic axi_arvalid_o,
	input logic axi_arready_i,
	input logic axi_awvalid_o,
	input logic axi_awready_i,
	input logic wb_valid_o,
	input logic stpb_committed
);

	int fail_cnt = 0;

	// valid is held until the slave takes it
	ar_hold: assert property (@(posedge CLK) disable iff (rst_i)
		axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o)
		else begin
			$error("ARVALID dropped before ARREADY");
			fail_cnt++;
		end

	aw_hold: assert property (@(posedge CLK) disable iff (rst_i)
		axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o)
		else begin
			$error("AWVALID dropped before AWREADY");
			fail_cnt++;
		end

	wb_pulse: assert property (@(posedge CLK) disable iff (rst_i)
		wb_valid_o |=> !wb_valid_o)
		else begin
			$error("wb_valid_o longer than one cycle");
			fail_cnt++;
		end

	// a write may only start from a committed head entry
	aw_committed: assert property (@(posedge CLK) disable iff (rst_i)
		$rose(axi_awvalid_o) |-> $past(stpb_committed))
		else begin
			$error("AWVALID raised without a committed entry");
			fail_cnt++;
		end

endmodule

bind lsu lsu_sva sva_inst (.*);

/* hdl/lsu.sv */
`timescale 1ns/10ps

module lsu (
	input logic CLK,
	input logic rst_i,

	input logic issue_valid_i,
	input lsu_pkg::lsu_op_e issue_op_i,
	input lsu_pkg::xlen_t issue_addr_i,
	input lsu_pkg::xlen_t issue_wdata_i,
	input lsu_pkg::rd_tag_t issue_rd_i,
	output logic issue_ready_o,

	output logic wb_valid_o,
	output lsu_pkg::xlen_t wb_res_o,
	output lsu_pkg::rd_tag_t wb_rd_o,

	input logic commit_i,
	input logic flush_i,
	output logic fault_o,
	output logic fencei_o,

	output lsu_pkg::paddr_t axi_awaddr_o,
	output logic axi_awvalid_o,
	input logic axi_awready_i,
	output lsu_pkg::xlen_t axi_wdata_o,
	output lsu_pkg::strb_t axi_wstrb_o,
	output logic axi_wvalid_o,
	input logic axi_wready_i,
	input logic axi_bvalid_i,
	output logic axi_bready_o,

	output lsu_pkg::paddr_t axi_araddr_o,
	output logic axi_arvalid_o,
	input logic axi_arready_i,
	input lsu_pkg::xlen_t axi_rdata_i,
	input logic axi_rvalid_i,
	output logic axi_rready_o
);

	logic is_load;
	logic is_store;
	logic [1:0] size;
	logic misalign;
	logic acc_fault;

	logic accept;
	logic ld_go;
	logic st_go;
	logic quick_done;

	lsu_pkg::strb_t strb_base;
	lsu_pkg::store_entry_t st_entry;
	lsu_pkg::store_entry_t stpb_head;
	lsu_pkg::paddr_t chk_addr;

	logic stpb_committed;
	logic stpb_full;
	logic stpb_hazard;
	logic stpb_pop;

	logic rd_done;
	logic rd_busy;
	lsu_pkg::xlen_t rd_res;

	logic wb_valid_q;
	logic fault_q;
	lsu_pkg::xlen_t wb_res_q;
	lsu_pkg::rd_tag_t wb_rd_q;

	// op classification
	assign is_load = (issue_op_i inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LD,
		lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU});
	assign is_store = (issue_op_i inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD});
	assign size = lsu_pkg::op_size(issue_op_i);

	always_comb begin
		case (size)
			2'd0: misalign = 1'b0;
			2'd1: misalign = issue_addr_i[0];
			2'd2: misalign = |issue_addr_i[1:0];
			default: misalign = |issue_addr_i[2:0];
		endcase
	end

	// only real memory accesses can fault, fences ignore the address
	assign acc_fault = (is_load | is_store) & ((|issue_addr_i[63:32]) | misalign);

	assign accept = issue_valid_i & ~flush_i;
	assign ld_go = accept & is_load & ~acc_fault;
	assign st_go = accept & is_store & ~acc_fault;
	assign quick_done = accept & ~ld_go;

	assign fencei_o = issue_valid_i & (issue_op_i == lsu_pkg::FENCE_I);
	assign issue_ready_o = ~rd_busy & ~stpb_full;

	// lane-aligned store entry
	assign strb_base = (size == 2'd0) ? 8'h01 :
		(size == 2'd1) ? 8'h03 :
		(size == 2'd2) ? 8'h0f : 8'hff;
	assign st_entry.addr = issue_addr_i[31:0];
	assign st_entry.strb = strb_base << issue_addr_i[2:0];
	assign st_entry.data = issue_wdata_i << {issue_addr_i[2:0], 3'b000};

	assign chk_addr = issue_valid_i ? issue_addr_i[31:0] : axi_araddr_o;

	stp_block #(
		.payload_t(lsu_pkg::store_entry_t)
	) stpb_inst (
		.CLK(CLK),
		.rst_i(rst_i),
		.push_i(st_go),
		.data_i(st_entry),
		.commit_i(commit_i),
		.pop_i(stpb_pop),
		.flush_i(flush_i),
		.chk_addr_i(chk_addr),
		.data_o(stpb_head),
		.committed_o(stpb_committed),
		.full_o(stpb_full),
		.hazard_o(stpb_hazard)
	);

	lsu_rd_chan rd_chan_inst (
		.CLK(CLK),
		.rst_i(rst_i),
		.start_i(ld_go),
		.addr_i(issue_addr_i[31:0]),
		.op_i(issue_op_i),
		.hold_i(stpb_hazard),
		.flush_i(flush_i),
		.araddr_o(axi_araddr_o),
		.arvalid_o(axi_arvalid_o),
		.arready_i(axi_arready_i),
		.rdata_i(axi_rdata_i),
		.rvalid_i(axi_rvalid_i),
		.rready_o(axi_rready_o),
		.done_o(rd_done),
		.res_o(rd_res),
		.busy_o(rd_busy)
	);

	lsu_wr_chan wr_chan_inst (
		.CLK(CLK),
		.rst_i(rst_i),
		.entry_i(stpb_head),
		.ready_i(stpb_committed),
		.pop_o(stpb_pop),
		.awaddr_o(axi_awaddr_o),
		.awvalid_o(axi_awvalid_o),
		.awready_i(axi_awready_i),
		.wdata_o(axi_wdata_o),
		.wstrb_o(axi_wstrb_o),
		.wvalid_o(axi_wvalid_o),
		.wready_i(axi_wready_i),
		.bvalid_i(axi_bvalid_i),
		.bready_o(axi_bready_o)
	);

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			wb_valid_q <= 1'b0;
			fault_q <= 1'b0;
		end else begin
			wb_valid_q <= quick_done | rd_done;
			if (flush_i) begin
				fault_q <= 1'b0;
			end else if (accept & acc_fault) begin
				fault_q <= 1'b1;
			end
		end
	end

	// stores, fences and faults write back zero
	always_ff @(posedge CLK) begin
		if (accept) begin
			wb_rd_q <= issue_rd_i;
		end
		wb_res_q <= rd_done ? rd_res : '0;
	end

	assign wb_valid_o = wb_valid_q;
	assign wb_res_o = wb_res_q;
	assign wb_rd_o = wb_rd_q;
	assign fault_o = fault_q;

endmodule

/* hdl/lsu_wr_chan.sv */
`timescale 1ns/10ps

module lsu_wr_chan (
	input logic CLK,
	input logic rst_i,

	input lsu_pkg::store_entry_t entry_i,
	input logic ready_i,
	output logic pop_o,

	output lsu_pkg::paddr_t awaddr_o,
	output logic awvalid_o,
	input logic awready_i,

	output lsu_pkg::xlen_t wdata_o,
	output lsu_pkg::strb_t wstrb_o,
	output logic wvalid_o,
	input logic wready_i,

	input logic bvalid_i,
	output logic bready_o
);

	lsu_pkg::store_entry_t cur_q;

	logic awvalid_q;
	logic wvalid_q;
	logic out_q;
	logic bready_q;
	logic launch;

	// one write in flight, next one waits for the B handshake
	assign launch = ready_i & ~out_q;

	// head is popped on AW, so W keeps its own copy
	always_ff @(posedge CLK) begin
		if (launch) begin
			cur_q <= entry_i;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			awvalid_q <= 1'b0;
			wvalid_q <= 1'b0;
			out_q <= 1'b0;
			bready_q <= 1'b0;
		end else begin
			if (launch) begin
				awvalid_q <= 1'b1;
				wvalid_q <= 1'b1;
				out_q <= 1'b1;
			end else begin
				if (awvalid_q & awready_i) begin
					awvalid_q <= 1'b0;
				end
				if (wvalid_q & wready_i) begin
					wvalid_q <= 1'b0;
				end
				if (bvalid_i & bready_q) begin
					out_q <= 1'b0;
				end
			end
			bready_q <= bvalid_i & out_q & ~bready_q;
		end
	end

	assign pop_o = awvalid_q & awready_i;
	assign awaddr_o = cur_q.addr;
	assign awvalid_o = awvalid_q;
	assign wdata_o = cur_q.data;
	assign wstrb_o = cur_q.strb;
	assign wvalid_o = wvalid_q;
	assign bready_o = bready_q;

endmodule

/* hdl/lsu_rd_chan.sv */
`timescale 1ns/10ps

module lsu_rd_chan (
	input logic CLK,
	input logic rst_i,

	input logic start_i,
	input lsu_pkg::paddr_t addr_i,
	input lsu_pkg::lsu_op_e op_i,
	input logic hold_i,
	input logic flush_i,

	output lsu_pkg::paddr_t araddr_o,
	output logic arvalid_o,
	input logic arready_i,

	input lsu_pkg::xlen_t rdata_i,
	input logic rvalid_i,
	output logic rready_o,

	output logic done_o,
	output lsu_pkg::xlen_t res_o,
	output logic busy_o
);

	lsu_pkg::paddr_t addr_q;
	logic [1:0] size_q;
	logic uns_q;

	logic ar_wait_q;
	logic arvalid_q;
	logic r_wait_q;
	logic rready_q;
	logic inval_q;

	logic ar_go;
	logic ar_hs;
	logic r_hs;
	lsu_pkg::xlen_t lane;

	// load attributes, held until the data returns
	always_ff @(posedge CLK) begin
		if (start_i) begin
			addr_q <= addr_i;
			size_q <= lsu_pkg::op_size(op_i);
			uns_q <= (op_i == lsu_pkg::LBU) || (op_i == lsu_pkg::LHU) ||
				(op_i == lsu_pkg::LWU);
		end
	end

	assign ar_go = (start_i | ar_wait_q) & ~hold_i & ~flush_i;
	assign ar_hs = arvalid_q & arready_i;
	assign r_hs = rvalid_i & rready_q;

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			ar_wait_q <= 1'b0;
			arvalid_q <= 1'b0;
			r_wait_q <= 1'b0;
			rready_q <= 1'b0;
			inval_q <= 1'b0;
		end else begin
			// a load still blocked by the hazard is simply dropped on flush
			ar_wait_q <= (start_i | ar_wait_q) & hold_i & ~flush_i;
			if (ar_go) begin
				arvalid_q <= 1'b1;
			end else if (ar_hs) begin
				arvalid_q <= 1'b0;
			end
			if (ar_hs) begin
				r_wait_q <= 1'b1;
			end else if (r_hs) begin
				r_wait_q <= 1'b0;
			end
			rready_q <= rvalid_i & r_wait_q & ~rready_q;
			// once on the bus the read must finish, its data is thrown away
			if (r_hs) begin
				inval_q <= 1'b0;
			end else if (flush_i & (arvalid_q | r_wait_q)) begin
				inval_q <= 1'b1;
			end
		end
	end

	assign lane = rdata_i >> {addr_q[2:0], 3'b000};

	always_comb begin
		case (size_q)
			2'd0: res_o = uns_q ? {56'b0, lane[7:0]} : {{56{lane[7]}}, lane[7:0]};
			2'd1: res_o = uns_q ? {48'b0, lane[15:0]} : {{48{lane[15]}}, lane[15:0]};
			2'd2: res_o = uns_q ? {32'b0, lane[31:0]} : {{32{lane[31]}}, lane[31:0]};
			default: res_o = lane;
		endcase
	end

	assign araddr_o = addr_q;
	assign arvalid_o = arvalid_q;
	assign rready_o = rready_q;
	assign done_o = r_hs & ~inval_q & ~flush_i;
	assign busy_o = ar_wait_q | arvalid_q | r_wait_q;

endmodule

/* hdl/stp_block.sv */
`timescale 1ns/10ps

module stp_block #(
	parameter type payload_t = lsu_pkg::store_entry_t,
	parameter int DEPTH = lsu_pkg::STPB_DEPTH
) (
	input logic CLK,
	input logic rst_i,

	input logic push_i,
	input payload_t data_i,
	input logic commit_i,
	input logic pop_i,
	input logic flush_i,
	input lsu_pkg::paddr_t chk_addr_i,

	output payload_t data_o,
	output logic committed_o,
	output logic full_o,
	output logic hazard_o
);

	localparam int IW = $clog2(DEPTH);

	// pointers carry one wrap bit above the index
	logic [IW:0] rd_ptr;
	logic [IW:0] cmt_ptr;
	logic [IW:0] wr_ptr;
	logic [IW:0] cmt_ptr_nxt;

	logic [DEPTH-1:0] vld;
	logic [DEPTH-1:0] cmt;
	logic [DEPTH-1:0] vld_nxt;
	logic [DEPTH-1:0] cmt_nxt;
	logic [DEPTH-1:0] match;

	logic push_ok;
	logic commit_ok;

	payload_t mem [DEPTH];

	assign push_ok = push_i & ~flush_i & ~full_o;
	// a commit with nothing uncommitted is ignored
	assign commit_ok = commit_i & (cmt_ptr != wr_ptr);
	assign cmt_ptr_nxt = commit_ok ? cmt_ptr + 1'b1 : cmt_ptr;

	assign full_o = (wr_ptr[IW] != rd_ptr[IW]) && (wr_ptr[IW-1:0] == rd_ptr[IW-1:0]);
	assign committed_o = (cmt_ptr != rd_ptr);
	assign data_o = mem[rd_ptr[IW-1:0]];

	always_comb begin
		vld_nxt = vld;
		cmt_nxt = cmt;
		if (commit_ok) begin
			cmt_nxt[cmt_ptr[IW-1:0]] = 1'b1;
		end
		if (pop_i) begin
			vld_nxt[rd_ptr[IW-1:0]] = 1'b0;
			cmt_nxt[rd_ptr[IW-1:0]] = 1'b0;
		end
		// flush keeps only the committed entries
		if (flush_i) begin
			vld_nxt = vld_nxt & cmt_nxt;
		end else if (push_ok) begin
			vld_nxt[wr_ptr[IW-1:0]] = 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			rd_ptr <= '0;
			cmt_ptr <= '0;
			wr_ptr <= '0;
			vld <= '0;
			cmt <= '0;
		end else begin
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			cmt_ptr <= cmt_ptr_nxt;
			if (flush_i) begin
				wr_ptr <= cmt_ptr_nxt;
			end else if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			vld <= vld_nxt;
			cmt <= cmt_nxt;
		end
	end

	always_ff @(posedge CLK) begin
		if (push_ok) begin
			mem[wr_ptr[IW-1:0]] <= data_i;
		end
	end

	// hazard on the same 8-byte granule
	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			match[i] = vld[i] &&
				(mem[i].addr[lsu_pkg::PADDR_W-1:3] == chk_addr_i[lsu_pkg::PADDR_W-1:3]);
		end
	end

	assign hazard_o = |match;

endmodule

/* hdl/lsu_pkg.sv */
package lsu_pkg;

	localparam int XLEN = 64;
	localparam int PADDR_W = 32;
	localparam int STRB_W = XLEN / 8;

	// rename bits appended to the 5-bit register index
	localparam int RB = 2;
	localparam int RD_W = 5 + RB;

	localparam int STPB_DEPTH = 8;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [PADDR_W-1:0] paddr_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [RD_W-1:0] rd_tag_t;

	typedef enum logic [3:0] {
		LB,
		LH,
		LW,
		LD,
		LBU,
		LHU,
		LWU,
		SB,
		SH,
		SW,
		SD,
		FENCE,
		FENCE_I,
		NOP
	} lsu_op_e;

	// data and strobe are already shifted to their byte lanes
	typedef struct packed {
		paddr_t addr;
		strb_t strb;
		xlen_t data;
	} store_entry_t;

	// log2 of the access size in bytes
	function automatic logic [1:0] op_size(lsu_op_e op);
		case (op)
			LB, LBU, SB: return 2'd0;
			LH, LHU, SH: return 2'd1;
			LW, LWU, SW: return 2'd2;
			default: return 2'd3;
		endcase
	endfunction

endpackage
